/* phase_timer.sv */
// phase timer
// free-running phase counter and the registered test, shift and trigger strobes

`timescale 1ns/1ps

module phase_timer import scan_test_pkg::*; #(
  parameter int PHASE_PERIOD = 16
) (
  input  logic        clk,
  input  logic        test_mask_reset_not,
  scan_cfg_if.cfg_dst cfg,
  output logic        test_tick,
  output logic        shift_tick,
  output logic        trig_tick
);

  localparam phase_t LAST_PHASE = phase_t'(PHASE_PERIOD - 1);

  phase_t phase_cnt;
  phase_t phase_next;
  phase_t shift_phase;

  assign phase_next = (phase_cnt == LAST_PHASE) ? '0 : phase_cnt + phase_t'(1);

  // shift point two counts ahead of the test point, wrapped into the period
  assign shift_phase = (cfg.test_delay >= phase_t'(2)) ?
                       cfg.test_delay - phase_t'(2) :
                       phase_t'(int'(cfg.test_delay) + PHASE_PERIOD - 2);

  // strobes compare against the next count so they line up with phase_cnt
  always_ff @(posedge clk) begin
    if (test_mask_reset_not) begin
      phase_cnt  <= '0;
      test_tick  <= 1'b0;
      shift_tick <= 1'b0;
      trig_tick  <= 1'b0;
    end else begin
      phase_cnt  <= phase_next;
      test_tick  <= (phase_next == cfg.test_delay);
      shift_tick <= (phase_next == shift_phase);
      trig_tick  <= (phase_next == cfg.trig_phase);
    end
  end

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# builds the scan test testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f verilog.f --top-module tb_scan_test -o tb_scan_test_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_scan_test_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "Simulation passed" "$LOG"; then
  exit 0
fi
echo "pass message not found in $LOG"
exit 1

/* scan_chain_reg.sv */
// scan chain pattern register
// loads the test pattern, shifts it out lsb first and counts the shifts

`timescale 1ns/1ps

module scan_chain_reg import scan_test_pkg::*; #(
  parameter int SCAN_BITS = 32
) (
  input  logic                 clk,
  input  logic                 test_mask_reset_not,
  input  logic [SCAN_BITS-1:0] pattern,
  scan_chain_if.chain          chain
);

  logic [SCAN_BITS-1:0] shift_reg;
  shift_cnt_t           shift_cnt;

  // ----------------------------------------------------------
  // pattern shift register
  // ----------------------------------------------------------

  always_ff @(posedge clk) begin
    if (chain.reg_load) begin
      shift_reg <= pattern;
    end else if (chain.reg_shift) begin
      // shift right, the next bit moves into bit 0
      shift_reg <= shift_reg >> 1;
    end
  end

  assign chain.bit0 = shift_reg[0];

  // ----------------------------------------------------------
  // shift counter
  // ----------------------------------------------------------

  always_ff @(posedge clk) begin
    if (test_mask_reset_not) begin
      shift_cnt <= '0;
    end else if (chain.reg_load) begin
      shift_cnt <= '0;
    end else if (chain.reg_shift) begin
      shift_cnt <= shift_cnt + shift_cnt_t'(1);
    end
  end

  // all pattern bits have been moved through bit 0
  assign chain.shift_done = (shift_cnt == shift_cnt_t'(SCAN_BITS));

endmodule

/* scan_sequencer.sv */
// scan test sequencer
// phase-aligned FSM that drives ASIC reset, trigger, scan_load and the serial pattern

`timescale 1ns/1ps

module scan_sequencer import scan_test_pkg::*; (
  input  logic        clk,
  input  logic        test_mask_reset_not,
  input  logic        run_start,
  scan_cfg_if.cfg_dst cfg,
  input  logic        test_tick,
  input  logic        shift_tick,
  input  logic        trig_tick,
  scan_chain_if.ctrl  ctrl,
  output logic        busy,
  output logic        asic_reset_not,
  output logic        scan_load,
  output logic        scan_in,
  output logic        vin_test_trig_out,
  output logic        status_done,
  output logic        repeat_done
);

  seq_state_t state;
  phase_t     delay_cnt;
  repeat_t    iter_cnt;

  // ----------------------------------------------------------
  // state machine and registered outputs
  // ----------------------------------------------------------

  always_ff @(posedge clk) begin
    if (test_mask_reset_not) begin
      state             <= IDLE;
      delay_cnt         <= '0;
      iter_cnt          <= '0;
      busy              <= 1'b0;
      asic_reset_not    <= 1'b1;
      scan_load         <= SCAN_MODE_LOAD_COMP;
      scan_in           <= 1'b0;
      vin_test_trig_out <= 1'b0;
      status_done       <= 1'b0;
      repeat_done       <= 1'b0;
      ctrl.reg_load     <= 1'b0;
      ctrl.reg_shift    <= 1'b0;
    end else begin
      // single cycle strobes
      ctrl.reg_load  <= 1'b0;
      ctrl.reg_shift <= 1'b0;
      repeat_done    <= 1'b0;

      case (state)
        IDLE: begin
          if (run_start) begin
            state         <= DELAY_TEST;
            busy          <= 1'b1;
            iter_cnt      <= '0;
            ctrl.reg_load <= 1'b1;
          end
        end

        DELAY_TEST: begin
          status_done <= 1'b0;
          if (test_tick) begin
            state <= RESET_PULSE;
            // mask set keeps the pixel reset high
            asic_reset_not <= cfg.reset_pulse_mask;
            scan_load      <= SCAN_MODE_SHIFT_IN;
          end
        end

        RESET_PULSE: begin
          if (test_tick) begin
            state          <= TRIG_HIGH_1;
            asic_reset_not <= 1'b1;
          end
        end

        TRIG_HIGH_1: begin
          if (trig_tick) begin
            vin_test_trig_out <= 1'b1;
          end
          if (test_tick) begin
            state <= TRIG_HIGH_2;
          end
        end

        TRIG_HIGH_2: begin
          if (trig_tick) begin
            vin_test_trig_out <= 1'b0;
          end
          if (test_tick) begin
            if (cfg.load_delay_disable) begin
              // no load window, go straight to shifting
              state   <= SHIFT_IN_0;
              scan_in <= ctrl.bit0;
            end else if (cfg.scan_load_delay == '0) begin
              state     <= SCANLOAD_HIGH_1;
              scan_load <= SCAN_MODE_LOAD_COMP;
            end else begin
              state     <= DELAY_SCANLOAD;
              delay_cnt <= phase_t'(1);
            end
          end
        end

        // waits scan_load_delay phase periods
        DELAY_SCANLOAD: begin
          if (test_tick) begin
            if (delay_cnt == cfg.scan_load_delay) begin
              state     <= SCANLOAD_HIGH_1;
              scan_load <= SCAN_MODE_LOAD_COMP;
            end else begin
              delay_cnt <= delay_cnt + phase_t'(1);
            end
          end
        end

        // the one-period parallel load window
        SCANLOAD_HIGH_1: begin
          if (test_tick) begin
            state     <= SCANLOAD_HIGH_2;
            scan_load <= SCAN_MODE_SHIFT_IN;
            scan_in   <= ctrl.bit0;
          end
        end

        // window closed, first pattern bit on scan_in
        SCANLOAD_HIGH_2: begin
          ctrl.reg_shift <= shift_tick;
          if (test_tick) begin
            state   <= SHIFT_IN_0;
            scan_in <= ctrl.bit0;
          end
        end

        SHIFT_IN_0: begin
          ctrl.reg_shift <= shift_tick;
          if (test_tick) begin
            state   <= SHIFT_IN;
            scan_in <= ctrl.bit0;
          end
        end

        // the last shift lands right on test_tick, so shift_done ends the period
        SHIFT_IN: begin
          ctrl.reg_shift <= shift_tick;
          if (ctrl.shift_done) begin
            state       <= DONE;
            scan_load   <= SCAN_MODE_LOAD_COMP;
            scan_in     <= 1'b0;
            status_done <= 1'b1;
          end else if (test_tick) begin
            scan_in <= ctrl.bit0;
          end
        end

        DONE: begin
          state    <= SAVE_ITER;
          iter_cnt <= iter_cnt + repeat_t'(1);
        end

        SAVE_ITER: begin
          if (iter_cnt >= cfg.repeat_count) begin
            state       <= REPEAT_DONE;
            repeat_done <= 1'b1;
          end else begin
            state         <= DELAY_TEST;
            ctrl.reg_load <= 1'b1;
          end
        end

        REPEAT_DONE: begin
          state <= IDLE;
          busy  <= 1'b0;
        end

        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

endmodule

/* scan_test_config.sv */
// scan test configuration register
// snapshots the settings on start so they stay fixed while a run is in progress

`timescale 1ns/1ps

module scan_test_config import scan_test_pkg::*; (
  input  logic               clk,
  input  logic               test_mask_reset_not,
  input  logic               start,
  input  logic               busy,
  input  phase_t             cfg_test_delay,
  input  phase_t             cfg_trig_phase,
  input  phase_t             cfg_scan_load_delay,
  input  logic               cfg_load_delay_disable,
  input  logic               cfg_reset_pulse_mask,
  input  repeat_t            cfg_repeat_count,
  scan_cfg_if.cfg_src        cfg,
  output logic               run_start
);

  logic capture;

  // busy rises one cycle after run_start, so that cycle is blocked here
  assign capture = start && !busy && !run_start;

  always_ff @(posedge clk) begin
    if (test_mask_reset_not) begin
      run_start              <= 1'b0;
      cfg.test_delay         <= '0;
      cfg.trig_phase         <= '0;
      cfg.scan_load_delay    <= '0;
      cfg.load_delay_disable <= 1'b0;
      cfg.repeat_count       <= '0;
      cfg.reset_pulse_mask   <= 1'b0;
    end else begin
      run_start <= capture;
      if (capture) begin
        cfg.test_delay         <= cfg_test_delay;
        cfg.trig_phase         <= cfg_trig_phase;
        cfg.scan_load_delay    <= cfg_scan_load_delay;
        cfg.load_delay_disable <= cfg_load_delay_disable;
        cfg.repeat_count       <= cfg_repeat_count;
        cfg.reset_pulse_mask   <= cfg_reset_pulse_mask;
      end
    end
  end

endmodule

/* scan_test_ifs.sv */
// scan test interfaces
// captured configuration bus and pattern register control bus

`timescale 1ns/1ps

// configuration held stable for a whole run
interface scan_cfg_if import scan_test_pkg::*; ();

  phase_t  test_delay;
  phase_t  trig_phase;
  phase_t  scan_load_delay;
  logic    load_delay_disable;
  repeat_t repeat_count;
  logic    reset_pulse_mask;

  modport cfg_src (
    output test_delay, trig_phase, scan_load_delay,
    output load_delay_disable, repeat_count, reset_pulse_mask
  );

  modport cfg_dst (
    input test_delay, trig_phase, scan_load_delay,
    input load_delay_disable, repeat_count, reset_pulse_mask
  );

endinterface

// load and shift commands toward the pattern register, status back
interface scan_chain_if ();

  logic reg_load;
  logic reg_shift;
  logic bit0;
  logic shift_done;

  modport ctrl (
    output reg_load, reg_shift,
    input  bit0, shift_done
  );

  modport chain (
    input  reg_load, reg_shift,
    output bit0, shift_done
  );

endinterface

/* scan_test_pkg.sv */
// scan test package
// widths, state encoding and scan mode levels shared by the scan test sequencer

package scan_test_pkg;

  // ----------------------------------------------------------
  // value types
  // ----------------------------------------------------------

  // phase counter value and phase settings
  typedef logic [5:0] phase_t;

  // repeat count and iteration counter
  typedef logic [10:0] repeat_t;

  // number of pattern bits already shifted out
  typedef logic [10:0] shift_cnt_t;

  // ----------------------------------------------------------
  // sequencer states
  // ----------------------------------------------------------

  typedef enum logic [3:0] {
    IDLE,
    DELAY_TEST,
    RESET_PULSE,
    TRIG_HIGH_1,
    TRIG_HIGH_2,
    DELAY_SCANLOAD,
    SCANLOAD_HIGH_1,
    SCANLOAD_HIGH_2,
    SHIFT_IN_0,
    SHIFT_IN,
    DONE,
    SAVE_ITER,
    REPEAT_DONE
  } seq_state_t;

  // scan_load levels toward the ASIC
  // low selects the serial shift path, high the parallel comparator load
  localparam logic SCAN_MODE_SHIFT_IN  = 1'b0;
  localparam logic SCAN_MODE_LOAD_COMP = 1'b1;

endpackage

/* scan_test_top.sv */
// scan test top level
// configuration register, phase timer, pattern register and sequencer

`timescale 1ns/1ps

module scan_test_top import scan_test_pkg::*; #(
  parameter int PHASE_PERIOD = 16,
  parameter int SCAN_BITS    = 32
) (
  input  logic                 clk,
  input  logic                 test_mask_reset_not,
  input  logic                 start,
  input  phase_t               cfg_test_delay,
  input  phase_t               cfg_trig_phase,
  input  phase_t               cfg_scan_load_delay,
  input  logic                 cfg_load_delay_disable,
  input  logic                 cfg_reset_pulse_mask,
  input  repeat_t              cfg_repeat_count,
  input  logic [SCAN_BITS-1:0] pattern,
  output logic                 asic_reset_not,
  output logic                 scan_load,
  output logic                 scan_in,
  output logic                 vin_test_trig_out,
  output logic                 status_done,
  output logic                 repeat_done,
  output logic                 busy
);

  scan_cfg_if   cfg_bus ();
  scan_chain_if chain_bus ();

  logic run_start;
  logic test_tick;
  logic shift_tick;
  logic trig_tick;

  scan_test_config scan_test_config_i (
    .clk                    (clk),
    .test_mask_reset_not    (test_mask_reset_not),
    .start                  (start),
    .busy                   (busy),
    .cfg_test_delay         (cfg_test_delay),
    .cfg_trig_phase         (cfg_trig_phase),
    .cfg_scan_load_delay    (cfg_scan_load_delay),
    .cfg_load_delay_disable (cfg_load_delay_disable),
    .cfg_reset_pulse_mask   (cfg_reset_pulse_mask),
    .cfg_repeat_count       (cfg_repeat_count),
    .cfg                    (cfg_bus.cfg_src),
    .run_start              (run_start)
  );

  phase_timer #(
    .PHASE_PERIOD (PHASE_PERIOD)
  ) phase_timer_i (
    .clk                 (clk),
    .test_mask_reset_not (test_mask_reset_not),
    .cfg                 (cfg_bus.cfg_dst),
    .test_tick           (test_tick),
    .shift_tick          (shift_tick),
    .trig_tick           (trig_tick)
  );

  scan_chain_reg #(
    .SCAN_BITS (SCAN_BITS)
  ) scan_chain_reg_i (
    .clk                 (clk),
    .test_mask_reset_not (test_mask_reset_not),
    .pattern             (pattern),
    .chain               (chain_bus.chain)
  );

  scan_sequencer scan_sequencer_i (
    .clk                 (clk),
    .test_mask_reset_not (test_mask_reset_not),
    .run_start           (run_start),
    .cfg                 (cfg_bus.cfg_dst),
    .test_tick           (test_tick),
    .shift_tick          (shift_tick),
    .trig_tick           (trig_tick),
    .ctrl                (chain_bus.ctrl),
    .busy                (busy),
    .asic_reset_not      (asic_reset_not),
    .scan_load           (scan_load),
    .scan_in             (scan_in),
    .vin_test_trig_out   (vin_test_trig_out),
    .status_done         (status_done),
    .repeat_done         (repeat_done)
  );

endmodule

/* tb_clock_gen.sv */
// testbench clock source
// free-running clock, period given by PERIOD_NS

`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int PERIOD_NS = 4
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
  end

  always #(PERIOD_NS / 2) clk = ~clk;

endmodule

/* tb_scan_test.sv */
// testbench for the scan test sequencer
// LFSR driven runs checked against a model of the phase-aligned sequence

`timescale 1ns/1ps

module tb_scan_test import scan_test_pkg::*; ();

  localparam int PHASE_PERIOD = 16;
  localparam int SCAN_BITS    = 32;
  localparam int RUNS         = 8;
  localparam int WAIT_LIMIT   = 4000;

  logic                 clk;
  logic                 test_mask_reset_not;
  logic                 start;
  phase_t               cfg_test_delay;
  phase_t               cfg_trig_phase;
  phase_t               cfg_scan_load_delay;
  logic                 cfg_load_delay_disable;
  logic                 cfg_reset_pulse_mask;
  repeat_t              cfg_repeat_count;
  logic [SCAN_BITS-1:0] pattern;
  logic                 asic_reset_not;
  logic                 scan_load;
  logic                 scan_in;
  logic                 vin_test_trig_out;
  logic                 status_done;
  logic                 repeat_done;
  logic                 busy;

  // expected behavior of the current run
  int                   exp_delay;
  int                   exp_load_delay;
  int                   exp_repeats;
  logic                 exp_mask;
  logic                 exp_disable;
  logic [SCAN_BITS-1:0] exp_pattern;

  logic [31:0] lfsr_state;
  int          main_errors;
  int          timeout_count;
  int          runs_done;

  // state of the negedge output monitor
  int   mon_errors;
  int   phase_now;
  int   trig_pulses;
  int   reset_pulses;
  int   load_windows;
  int   shift_ends;
  int   done_pulses;
  int   trig_len;
  int   reset_len;
  int   window_len;
  int   load_periods;
  logic prev_trig;
  logic prev_rst_n;
  logic prev_load;
  logic trig_fell;
  logic in_window;
  logic samples[$];

  tb_clock_gen #(
    .PERIOD_NS (4)
  ) tb_clock_gen_i (
    .clk (clk)
  );

  scan_test_top #(
    .PHASE_PERIOD (PHASE_PERIOD),
    .SCAN_BITS    (SCAN_BITS)
  ) scan_test_top_i (
    .clk                    (clk),
    .test_mask_reset_not    (test_mask_reset_not),
    .start                  (start),
    .cfg_test_delay         (cfg_test_delay),
    .cfg_trig_phase         (cfg_trig_phase),
    .cfg_scan_load_delay    (cfg_scan_load_delay),
    .cfg_load_delay_disable (cfg_load_delay_disable),
    .cfg_reset_pulse_mask   (cfg_reset_pulse_mask),
    .cfg_repeat_count       (cfg_repeat_count),
    .pattern                (pattern),
    .asic_reset_not         (asic_reset_not),
    .scan_load              (scan_load),
    .scan_in                (scan_in),
    .vin_test_trig_out      (vin_test_trig_out),
    .status_done            (status_done),
    .repeat_done            (repeat_done),
    .busy                   (busy)
  );

  // ----------------------------------------------------------
  // helpers
  // ----------------------------------------------------------

  // galois form with taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0]) begin
      n = n ^ 32'h8020_0003;
    end
    return n;
  endfunction

  task automatic take_bits(input int count, output int val);
    val = 0;
    for (int i = 0; i < count; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      val = (val << 1) | int'(lfsr_state[0]);
    end
  endtask

  task automatic report_error(input string msg);
    $display("[ERROR] %0t: %s", $time, msg);
  endtask

  // inputs change 1 ns after the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic wait_busy(input logic level);
    int n;
    n = 0;
    while (busy !== level && n < WAIT_LIMIT) begin
      next_cycle();
      n++;
    end
    if (busy !== level) begin
      timeout_count++;
      $display("timeout: busy did not become %0b within %0d cycles", level, WAIT_LIMIT);
    end
  endtask

  task automatic wait_repeat_done();
    int n;
    n = 0;
    while (repeat_done !== 1'b1 && n < WAIT_LIMIT) begin
      next_cycle();
      n++;
    end
    if (repeat_done !== 1'b1) begin
      timeout_count++;
      $display("timeout: repeat_done did not pulse within %0d cycles", WAIT_LIMIT);
    end
  endtask

  // compares the serial samples of one iteration with the pattern lsb first
  task automatic check_pattern();
    if (samples.size() != SCAN_BITS) begin
      mon_errors++;
      report_error($sformatf("%0d serial samples before scan_load rose, expected %0d",
                             samples.size(), SCAN_BITS));
    end else begin
      for (int i = 0; i < SCAN_BITS; i++) begin
        if (samples[i] !== exp_pattern[i]) begin
          mon_errors++;
          report_error($sformatf("scan_in bit %0d is %0b, expected %0b",
                                 i, samples[i], exp_pattern[i]));
        end
      end
    end
    samples.delete();
  endtask

  // ----------------------------------------------------------
  // output monitor sampling in the middle of each clock cycle
  // ----------------------------------------------------------

  always @(negedge clk) begin
    if (test_mask_reset_not) begin
      // phase counter reads 0 in the first cycle after reset
      phase_now    = PHASE_PERIOD - 1;
      mon_errors   = 0;
      trig_pulses  = 0;
      reset_pulses = 0;
      load_windows = 0;
      shift_ends   = 0;
      done_pulses  = 0;
      trig_len     = 0;
      reset_len    = 0;
      window_len   = 0;
      load_periods = 0;
      prev_trig    = 1'b0;
      prev_rst_n   = 1'b1;
      prev_load    = 1'b1;
      trig_fell    = 1'b0;
      in_window    = 1'b0;
      samples.delete();
    end else begin
      phase_now = (phase_now + 1) % PHASE_PERIOD;

      if (vin_test_trig_out) begin
        if (!prev_trig) begin
          trig_pulses++;
          trig_len     = 0;
          trig_fell    = 1'b0;
          load_periods = 0;
          samples.delete();
        end
        trig_len++;
      end else if (prev_trig) begin
        trig_fell = 1'b1;
        if (trig_len != PHASE_PERIOD) begin
          mon_errors++;
          report_error($sformatf("trigger high for %0d cycles, expected %0d",
                                 trig_len, PHASE_PERIOD));
        end
      end

      // state boundaries counted from the trigger rise
      if (phase_now == (exp_delay + 1) % PHASE_PERIOD) begin
        load_periods++;
        // without a load window the pattern starts at the second boundary
        if (load_periods == 2) begin
          samples.delete();
        end
      end

      if (!asic_reset_not) begin
        if (prev_rst_n) begin
          reset_pulses++;
          reset_len = 0;
        end
        reset_len++;
      end else if (!prev_rst_n && reset_len != PHASE_PERIOD) begin
        mon_errors++;
        report_error($sformatf("pixel reset low for %0d cycles, expected %0d",
                               reset_len, PHASE_PERIOD));
      end

      // scan_load rises for a load window, or with status_done at the end of the shift
      if (scan_load && !prev_load) begin
        if (status_done) begin
          shift_ends++;
          check_pattern();
        end else begin
          load_windows++;
          in_window  = 1'b1;
          window_len = 0;
          samples.delete();
          if (!trig_fell) begin
            mon_errors++;
            report_error("load window opened before the trigger pulse ended");
          end
          if (load_periods != 2 + exp_load_delay) begin
            mon_errors++;
            report_error($sformatf("load window opened in period %0d, expected %0d",
                                   load_periods, 2 + exp_load_delay));
          end
        end
      end
      if (in_window) begin
        if (scan_load) begin
          window_len++;
        end else begin
          in_window = 1'b0;
          if (window_len != PHASE_PERIOD) begin
            mon_errors++;
            report_error($sformatf("load window lasted %0d cycles, expected %0d",
                                   window_len, PHASE_PERIOD));
          end
        end
      end

      // outputs move after the test point, so mid period is half a period later
      if (!scan_load && phase_now == (exp_delay + 1 + PHASE_PERIOD / 2) % PHASE_PERIOD) begin
        samples.push_back(scan_in);
      end

      if (repeat_done) begin
        done_pulses++;
      end

      prev_trig  = vin_test_trig_out;
      prev_rst_n = asic_reset_not;
      prev_load  = scan_load;
    end
  end

  // ----------------------------------------------------------
  // one run with random settings
  // ----------------------------------------------------------

  task automatic run_test();
    int v;
    int base_trig;
    int base_reset;
    int base_window;
    int base_shift;
    int base_done;

    for (int i = 0; i < SCAN_BITS; i++) begin
      take_bits(1, v);
      exp_pattern[i] = v[0];
    end
    pattern = exp_pattern;
    take_bits(6, v);
    exp_delay      = v % PHASE_PERIOD;
    cfg_test_delay = phase_t'(exp_delay);
    take_bits(6, v);
    cfg_trig_phase = phase_t'(v % PHASE_PERIOD);
    take_bits(2, v);
    exp_load_delay      = v;
    cfg_scan_load_delay = phase_t'(exp_load_delay);
    take_bits(1, v);
    exp_disable            = v[0];
    cfg_load_delay_disable = exp_disable;
    take_bits(1, v);
    exp_mask             = v[0];
    cfg_reset_pulse_mask = exp_mask;
    take_bits(2, v);
    exp_repeats      = v % 3 + 1;
    cfg_repeat_count = repeat_t'(exp_repeats);

    base_trig   = trig_pulses;
    base_reset  = reset_pulses;
    base_window = load_windows;
    base_shift  = shift_ends;
    base_done   = done_pulses;

    start = 1'b1;
    next_cycle();
    start = 1'b0;
    wait_busy(1'b1);
    if (timeout_count != 0) return;

    // a second start in the middle of the run has to be ignored
    repeat (3 * PHASE_PERIOD) next_cycle();
    if (busy !== 1'b1) begin
      main_errors++;
      report_error("busy dropped early in the run");
    end
    take_bits(6, v);
    cfg_test_delay = phase_t'(v % PHASE_PERIOD);
    take_bits(1, v);
    cfg_load_delay_disable = v[0];
    take_bits(1, v);
    cfg_reset_pulse_mask = v[0];
    take_bits(2, v);
    cfg_repeat_count = repeat_t'(v % 3 + 1);
    start = 1'b1;
    next_cycle();
    start = 1'b0;

    wait_repeat_done();
    if (timeout_count != 0) return;
    if (status_done !== 1'b1) begin
      main_errors++;
      report_error("status_done low in the repeat_done cycle");
    end
    wait_busy(1'b0);
    if (timeout_count != 0) return;
    repeat (2 * PHASE_PERIOD) next_cycle();

    if (busy !== 1'b0) begin
      main_errors++;
      report_error("sequencer restarted after the run ended");
    end
    if (trig_pulses - base_trig != exp_repeats) begin
      main_errors++;
      report_error($sformatf("%0d trigger pulses, expected %0d",
                             trig_pulses - base_trig, exp_repeats));
    end
    if (reset_pulses - base_reset != (exp_mask ? 0 : exp_repeats)) begin
      main_errors++;
      report_error($sformatf("%0d pixel reset pulses with mask %0b",
                             reset_pulses - base_reset, exp_mask));
    end
    if (load_windows - base_window != (exp_disable ? 0 : exp_repeats)) begin
      main_errors++;
      report_error($sformatf("%0d load windows with load delay disable %0b",
                             load_windows - base_window, exp_disable));
    end
    if (shift_ends - base_shift != exp_repeats) begin
      main_errors++;
      report_error($sformatf("%0d pattern shifts, expected %0d",
                             shift_ends - base_shift, exp_repeats));
    end
    if (done_pulses - base_done != 1) begin
      main_errors++;
      report_error($sformatf("%0d repeat_done pulses, expected 1", done_pulses - base_done));
    end
  endtask

  // ----------------------------------------------------------
  // main sequence
  // ----------------------------------------------------------

  initial begin
    test_mask_reset_not    = 1'b1;
    start                  = 1'b0;
    cfg_test_delay         = '0;
    cfg_trig_phase         = '0;
    cfg_scan_load_delay    = '0;
    cfg_load_delay_disable = 1'b0;
    cfg_reset_pulse_mask   = 1'b0;
    cfg_repeat_count       = '0;
    pattern                = '0;
    exp_delay              = 0;
    exp_load_delay         = 0;
    exp_repeats            = 0;
    exp_mask               = 1'b0;
    exp_disable            = 1'b0;
    exp_pattern            = '0;
    lfsr_state             = 32'h9307;
    main_errors            = 0;
    timeout_count          = 0;
    runs_done              = 0;

    repeat (5) @(posedge clk);
    #1;
    test_mask_reset_not = 1'b0;

    // outputs keep their reset levels until the first start
    repeat (4) begin
      next_cycle();
      if (asic_reset_not !== 1'b1 || scan_load !== 1'b1 || scan_in !== 1'b0 ||
          vin_test_trig_out !== 1'b0 || status_done !== 1'b0 ||
          repeat_done !== 1'b0 || busy !== 1'b0) begin
        main_errors++;
        report_error("outputs differ from their reset values before the first start");
      end
    end

    while (runs_done < RUNS && timeout_count == 0) begin
      run_test();
      runs_done++;
    end

    $display("runs: %0d, errors: %0d, timeouts: %0d",
             runs_done, main_errors + mon_errors, timeout_count);
    if (main_errors + mon_errors + timeout_count == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* verilog.f */
scan_test_pkg.sv
scan_test_ifs.sv
scan_test_config.sv
phase_timer.sv
scan_chain_reg.sv
scan_sequencer.sv
scan_test_top.sv
tb_clock_gen.sv
tb_scan_test.sv
